// File: list.f
logic/ex_pkg.sv
logic/ex_issue_if.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_muldiv.sv
logic/ex_stage.sv
verif/ex_properties.sv
verif/ex_tb.sv

// File: logic/ex_alu.sv
// Single-cycle ALU; shifts use opb[4:0] only, result holds until the next ALU issue
`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  ex_issue_if.unit        issue,
  output logic            alu_valid_o,
  output logic [XLEN-1:0] alu_r_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////////////////////////////////////////

  logic            alu_sel;
  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_r;

  // Issue belongs to this unit
  assign alu_sel = issue.valid && (op_unit(issue.op) == UNIT_ALU);

  // RV32 shift amount
  assign shamt = issue.opb[4:0];

  always_comb
  begin
    case (issue.op)
      OP_ADD:
        alu_r = issue.opa + issue.opb;
      OP_SUB:
        alu_r = issue.opa - issue.opb;
      OP_AND:
        alu_r = issue.opa & issue.opb;
      OP_OR:
        alu_r = issue.opa | issue.opb;
      OP_XOR:
        alu_r = issue.opa ^ issue.opb;
      OP_SLL:
        alu_r = issue.opa << shamt;
      OP_SRL:
        alu_r = issue.opa >> shamt;
      // Arithmetic shift keeps the sign
      OP_SRA:
        alu_r = $unsigned($signed(issue.opa) >>> shamt);
      OP_SLT:
        alu_r = {{(XLEN-1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
      OP_SLTU:
        alu_r = {{(XLEN-1){1'b0}}, issue.opa < issue.opb};
      // NOP and foreign ops
      default:
        alu_r = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // One-cycle strobe after issue
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      alu_valid_o <= 1'b0;
    end
    else
    begin
      alu_valid_o <= alu_sel;
    end
  end

  // Result, kept for the bypass
  always_ff @(posedge clk_i)
  begin
    if (alu_sel)
    begin
      alu_r_o <= alu_r;
    end
  end

endmodule

`default_nettype wire

// File: logic/ex_branch.sv
// Static-prediction check only; no history outputs, flush and btaken are one-cycle pulses
`timescale 1ns/1ps
`default_nettype none

module ex_branch
  import ex_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  ex_issue_if.unit        issue,
  input  logic            bp_taken_i,
  output logic            bu_valid_o,
  output logic [XLEN-1:0] bu_r_o,
  output logic            bu_flush_o,
  output logic [XLEN-1:0] bu_nxt_pc_o,
  output logic            bu_btaken_o
);

  logic            bu_sel;
  logic            is_jump;
  logic            taken;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] target;

  assign bu_sel  = issue.valid && (op_unit(issue.op) == UNIT_BRANCH);
  assign is_jump = (issue.op == OP_JAL) || (issue.op == OP_JALR);

  // Fall-through and link address
  assign pc_plus4 = issue.pc + XLEN'(4);

  // JALR target is register based, LSB forced low
  assign jalr_sum = issue.opa + issue.imm;
  assign target   = (issue.op == OP_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                          : issue.pc + issue.imm;

  // Condition evaluation
  always_comb
  begin
    case (issue.op)
      OP_BEQ:
        taken = issue.opa == issue.opb;
      OP_BNE:
        taken = issue.opa != issue.opb;
      OP_BLT:
        taken = $signed(issue.opa) < $signed(issue.opb);
      OP_BGE:
        taken = $signed(issue.opa) >= $signed(issue.opb);
      OP_BLTU:
        taken = issue.opa < issue.opb;
      OP_BGEU:
        taken = issue.opa >= issue.opb;
      // Jumps always go
      OP_JAL, OP_JALR:
        taken = 1'b1;
      default:
        taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Resolution registers
  ////////////////////////////////////////////////////////////////////////////

  // Strobes, low unless a branch resolved last cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bu_valid_o  <= 1'b0;
      bu_flush_o  <= 1'b0;
      bu_btaken_o <= 1'b0;
    end
    else
    begin
      bu_valid_o  <= bu_sel;
      // Mispredict in either direction
      bu_flush_o  <= bu_sel && (taken != bp_taken_i);
      bu_btaken_o <= bu_sel && taken;
    end
  end

  // Link value and corrected PC
  always_ff @(posedge clk_i)
  begin
    if (bu_sel)
    begin
      // Conditional branches write zero
      bu_r_o      <= is_jump ? pc_plus4 : '0;
      bu_nxt_pc_o <= taken ? target : pc_plus4;
    end
  end

endmodule

`default_nettype wire

// File: logic/ex_issue_if.sv
// One issue per valid strobe, no handshake back; operands arrive already bypassed
`timescale 1ns/1ps
`default_nettype none

interface ex_issue_if
  import ex_pkg::*;
();

  // Issue strobe, one cycle per instruction
  logic            valid;
  // Decoded operation
  ex_op_t          op;
  // PC of the issued instruction
  logic [XLEN-1:0] pc;
  // Branch offset
  logic [XLEN-1:0] imm;
  // Operands after bypass selection
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;

  // Driver side, the stage top
  modport stage (
    output valid, op, pc, imm, opa, opb
  );

  // Receiver side, every execution unit
  modport unit (
    input valid, op, pc, imm, opa, opb
  );

endinterface

`default_nettype wire

// File: logic/ex_muldiv.sv
// Iterative 32-step mul/div, 33-cycle latency; no signed-high multiply, one op in flight
`timescale 1ns/1ps
`default_nettype none

module ex_muldiv
  import ex_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  ex_issue_if.unit        issue,
  output logic            md_valid_o,
  output logic [XLEN-1:0] md_r_o,
  output logic            md_busy_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Issue decode and operand magnitudes
  ////////////////////////////////////////////////////////////////////////////

  logic                      md_sel;
  logic                      is_div;
  logic                      is_signed;
  logic                      a_neg;
  logic                      b_neg;
  logic [XLEN-1:0]           a_mag;
  logic [XLEN-1:0]           b_mag;

  // Working state
  ex_op_t                    op_q;
  logic [2*XLEN-1:0]         acc_q;
  logic [XLEN-1:0]           opnd_q;
  logic                      neg_quo_q;
  logic                      neg_rem_q;
  logic [$clog2(XLEN)-1:0]   cnt_q;

  // Step datapath
  logic                      step_div;
  logic [XLEN:0]             mul_sum;
  logic [XLEN:0]             div_diff;
  logic [2*XLEN-1:0]         acc_step;
  logic [XLEN-1:0]           quo;
  logic [XLEN-1:0]           rem;
  logic [XLEN-1:0]           md_r;

  assign md_sel    = issue.valid && (op_unit(issue.op) == UNIT_MULDIV);
  assign is_div    = issue.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign is_signed = issue.op inside {OP_DIV, OP_REM};

  // Signed divide runs on magnitudes
  assign a_neg = is_signed && issue.opa[XLEN-1];
  assign b_neg = is_signed && issue.opb[XLEN-1];
  assign a_mag = a_neg ? -issue.opa : issue.opa;
  assign b_mag = b_neg ? -issue.opb : issue.opb;

  ////////////////////////////////////////////////////////////////////////////
  // One iteration
  ////////////////////////////////////////////////////////////////////////////

  assign step_div = op_q inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

  // Shift-and-add, carry kept in the top bit
  assign mul_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, opnd_q} : '0);

  // Trial subtract on the shifted partial remainder
  assign div_diff = acc_q[2*XLEN-1:XLEN-1] - {1'b0, opnd_q};

  always_comb
  begin
    if (step_div)
    begin
      // Borrow means restore, quotient bit 0
      if (div_diff[XLEN])
        acc_step = {acc_q[2*XLEN-2:0], 1'b0};
      else
        acc_step = {div_diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
    end
    else
    begin
      acc_step = {mul_sum, acc_q[XLEN-1:1]};
    end
  end

  // Final step result, low half quotient, high half remainder
  assign quo = acc_step[XLEN-1:0];
  assign rem = acc_step[2*XLEN-1:XLEN];

  always_comb
  begin
    case (op_q)
      OP_MUL:
        md_r = acc_step[XLEN-1:0];
      OP_MULHU:
        md_r = acc_step[2*XLEN-1:XLEN];
      OP_DIV, OP_DIVU:
        md_r = neg_quo_q ? -quo : quo;
      OP_REM, OP_REMU:
        md_r = neg_rem_q ? -rem : rem;
      default:
        md_r = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  // Busy for 32 cycles, done strobe as busy drops
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      md_busy_o  <= 1'b0;
      md_valid_o <= 1'b0;
      cnt_q      <= '0;
    end
    else
    begin
      md_valid_o <= 1'b0;
      if (md_sel)
      begin
        md_busy_o <= 1'b1;
        cnt_q     <= '0;
      end
      else if (md_busy_o)
      begin
        cnt_q <= cnt_q + 1'b1;
        if (&cnt_q)
        begin
          md_busy_o  <= 1'b0;
          md_valid_o <= 1'b1;
        end
      end
    end
  end

  // Operand load and iteration
  always_ff @(posedge clk_i)
  begin
    if (md_sel)
    begin
      op_q      <= issue.op;
      // Multiplier in the low half, multiplicand aside
      acc_q     <= {{XLEN{1'b0}}, (is_div ? a_mag : issue.opb)};
      opnd_q    <= is_div ? b_mag : issue.opa;
      // Zero divisor keeps an all-ones quotient
      neg_quo_q <= (a_neg ^ b_neg) && (|issue.opb);
      neg_rem_q <= a_neg;
    end
    else if (md_busy_o)
    begin
      acc_q <= acc_step;
    end
  end

  // Result held for the bypass
  always_ff @(posedge clk_i)
  begin
    if (md_busy_o && (&cnt_q))
    begin
      md_r_o <= md_r;
    end
  end

endmodule

`default_nettype wire

// File: logic/ex_pkg.sv
// RV32 EX stage definitions; no signed-high multiplies, XLEN fixed at 32
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and reset values
  ////////////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;

  // PC presented by the stage out of reset
  localparam logic [XLEN-1:0] PC_INIT = 32'h200;

  ////////////////////////////////////////////////////////////////////////////
  // Operation and unit encodings
  ////////////////////////////////////////////////////////////////////////////

  // Operations as sent by decode
  typedef enum logic [4:0] {
    // ALU
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    // Branch unit
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR,
    // Multiply/divide unit
    OP_MUL, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    // Bubble, executed by the ALU with a zero result
    OP_NOP
  } ex_op_t;

  // Execution unit owning an operation
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_BRANCH,
    UNIT_MULDIV
  } ex_unit_e;

  // Shared ownership decode, so units and top never disagree
  function automatic ex_unit_e op_unit(input ex_op_t op);
    ex_unit_e unit;
    case (op)
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR:
        unit = UNIT_BRANCH;
      OP_MUL, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU:
        unit = UNIT_MULDIV;
      default:
        unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

`default_nettype wire

// File: logic/ex_stage.sv
// EX stage top; no LSU or CSR, decode must not issue during stall or right after a mul/div
`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  // From decode
  input  logic            id_valid_i,
  input  ex_op_t          id_op_i,
  input  logic [XLEN-1:0] id_pc_i,
  input  logic [XLEN-1:0] id_imm_i,
  input  logic [XLEN-1:0] id_opa_i,
  input  logic [XLEN-1:0] id_opb_i,
  input  logic            id_bypa_i,
  input  logic            id_bypb_i,
  input  logic            id_bp_taken_i,
  // To memory stage
  output logic            ex_valid_o,
  output logic [XLEN-1:0] ex_r_o,
  output logic [XLEN-1:0] ex_pc_o,
  output logic            ex_stall_o,
  // To fetch
  output logic            bu_flush_o,
  output logic [XLEN-1:0] bu_nxt_pc_o,
  output logic            bu_btaken_o
);

  ex_issue_if issue ();

  logic            alu_valid;
  logic [XLEN-1:0] alu_r;
  logic            bu_valid;
  logic [XLEN-1:0] bu_r;
  logic            md_valid;
  logic [XLEN-1:0] md_r;
  logic            md_busy;
  ex_unit_e        id_unit;
  ex_unit_e        res_unit_q;

  assign id_unit = op_unit(id_op_i);

  ////////////////////////////////////////////////////////////////////////////
  // PC and operand bypass
  ////////////////////////////////////////////////////////////////////////////

  // PC follows every strobe
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ex_pc_o <= PC_INIT;
    end
    else if (id_valid_i)
    begin
      ex_pc_o <= id_pc_i;
    end
  end

  assign issue.valid = id_valid_i;
  assign issue.op    = id_op_i;
  assign issue.pc    = id_pc_i;
  assign issue.imm   = id_imm_i;
  // EX-to-EX forwarding of the last presented result
  assign issue.opa   = id_bypa_i ? ex_r_o : id_opa_i;
  assign issue.opb   = id_bypb_i ? ex_r_o : id_opb_i;

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu i_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue       (issue),
    .alu_valid_o (alu_valid),
    .alu_r_o     (alu_r)
  );

  ex_branch i_branch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue       (issue),
    .bp_taken_i  (id_bp_taken_i),
    .bu_valid_o  (bu_valid),
    .bu_r_o      (bu_r),
    .bu_flush_o  (bu_flush_o),
    .bu_nxt_pc_o (bu_nxt_pc_o),
    .bu_btaken_o (bu_btaken_o)
  );

  ex_muldiv i_muldiv (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue      (issue),
    .md_valid_o (md_valid),
    .md_r_o     (md_r),
    .md_busy_o  (md_busy)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result combining
  ////////////////////////////////////////////////////////////////////////////

  // Owner of the presented result
  // Mul/div takes over only when done, so ex_r_o holds during the stall
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      res_unit_q <= UNIT_ALU;
    end
    else if (id_valid_i && (id_unit != UNIT_MULDIV))
    begin
      res_unit_q <= id_unit;
    end
    else if (md_valid)
    begin
      res_unit_q <= UNIT_MULDIV;
    end
  end

  always_comb
  begin
    // Done strobe wins, owner register updates one cycle later
    if (md_valid)
    begin
      ex_r_o = md_r;
    end
    else
    begin
      case (res_unit_q)
        UNIT_BRANCH:
          ex_r_o = bu_r;
        UNIT_MULDIV:
          ex_r_o = md_r;
        default:
          ex_r_o = alu_r;
      endcase
    end
  end

  assign ex_valid_o = alu_valid | bu_valid | md_valid;
  assign ex_stall_o = md_busy;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module ex_tb -f list.f -o ex_sim || exit 1
out=$(./obj_dir/ex_sim)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1

// File: verif/ex_properties.sv
// Checks stage strobes only, no data; assumes rst_ni is low from time zero
`timescale 1ns/1ps
`default_nettype none

module ex_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic id_valid_i,
  input logic ex_valid_o,
  input logic ex_stall_o,
  input logic bu_flush_o,
  input logic bu_btaken_o
);

  // Result and stall only overlap as the stall drops
  a_valid_vs_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ex_valid_o && ex_stall_o) || $fell(ex_stall_o))
    else $error("ex_valid_o and ex_stall_o high together");

  // Decode holds off while mul/div is busy
  a_no_issue_in_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_stall_o |-> !id_valid_i)
    else $error("issue while ex_stall_o is high");

  // Flush only with a presented branch
  a_flush_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu_flush_o |-> ex_valid_o)
    else $error("bu_flush_o without ex_valid_o");

  // Quiet outputs while in reset
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !(ex_valid_o || ex_stall_o || bu_flush_o || bu_btaken_o))
    else $error("strobe high during reset");

endmodule

`default_nettype wire

// File: verif/ex_tb.sv
// Random EX stage traffic with a fixed seed; bypass only used once a result exists
`timescale 1ns/1ps
`default_nettype none

module ex_tb
  import ex_pkg::*;
();

  localparam int N_ALU    = 200;
  localparam int N_BRANCH = 200;
  localparam int N_MULDIV = 100;
  localparam int N_BYPASS = 80;
  // Worst issue is a mul/div of about 35 cycles
  localparam int TIMEOUT  = (N_ALU + N_BRANCH + N_MULDIV + N_BYPASS) * 40 + 200;

  logic            clk_i;
  logic            rst_ni;
  logic            id_valid_i;
  ex_op_t          id_op_i;
  logic [XLEN-1:0] id_pc_i;
  logic [XLEN-1:0] id_imm_i;
  logic [XLEN-1:0] id_opa_i;
  logic [XLEN-1:0] id_opb_i;
  logic            id_bypa_i;
  logic            id_bypb_i;
  logic            id_bp_taken_i;
  logic            ex_valid_o;
  logic [XLEN-1:0] ex_r_o;
  logic [XLEN-1:0] ex_pc_o;
  logic            ex_stall_o;
  logic            bu_flush_o;
  logic [XLEN-1:0] bu_nxt_pc_o;
  logic            bu_btaken_o;

  // Model state, last result seen by the bypass
  logic [XLEN-1:0] last_r;
  int              checks;
  int              errors;
  int              base_errors;
  int              cycles = 0;
  string           test_name;

  // ALU or branch result due in the next cycle
  logic            pend;
  logic            pend_br;
  logic [XLEN-1:0] pend_r;
  logic [XLEN-1:0] pend_pc;
  logic [XLEN-1:0] pend_nxt;
  logic            pend_taken;
  logic            pend_flush;

  ex_stage i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .id_valid_i    (id_valid_i),
    .id_op_i       (id_op_i),
    .id_pc_i       (id_pc_i),
    .id_imm_i      (id_imm_i),
    .id_opa_i      (id_opa_i),
    .id_opb_i      (id_opb_i),
    .id_bypa_i     (id_bypa_i),
    .id_bypb_i     (id_bypb_i),
    .id_bp_taken_i (id_bp_taken_i),
    .ex_valid_o    (ex_valid_o),
    .ex_r_o        (ex_r_o),
    .ex_pc_o       (ex_pc_o),
    .ex_stall_o    (ex_stall_o),
    .bu_flush_o    (bu_flush_o),
    .bu_nxt_pc_o   (bu_nxt_pc_o),
    .bu_btaken_o   (bu_btaken_o)
  );

  bind ex_stage ex_properties i_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .id_valid_i  (id_valid_i),
    .ex_valid_o  (ex_valid_o),
    .ex_stall_o  (ex_stall_o),
    .bu_flush_o  (bu_flush_o),
    .bu_btaken_o (bu_btaken_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #4 clk_i = ~clk_i;
    end
  end

  // Run limit
  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [XLEN-1:0] exp,
                       input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  function automatic logic ref_taken(input ex_op_t op, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
    case (op)
      OP_BEQ: return a == b;
      OP_BNE: return a != b;
      OP_BLT: return $signed(a) < $signed(b);
      OP_BGE: return $signed(a) >= $signed(b);
      OP_BLTU: return a < b;
      OP_BGEU: return a >= b;
      OP_JAL, OP_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_result(input ex_op_t op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic [XLEN-1:0] pc);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [2*XLEN-1:0]      prod;
    logic                   ovf;
    sa   = a;
    sb   = b;
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    // Most negative divided by minus one
    ovf  = (a == 32'h8000_0000) && (b == '1);
    case (op)
      OP_ADD: return a + b;
      OP_SUB: return a - b;
      OP_AND: return a & b;
      OP_OR: return a | b;
      OP_XOR: return a ^ b;
      OP_SLL: return a << b[4:0];
      OP_SRL: return a >> b[4:0];
      OP_SRA: return $unsigned(sa >>> b[4:0]);
      OP_SLT: return {{(XLEN-1){1'b0}}, sa < sb};
      OP_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      // Links; conditional branches present zero
      OP_JAL, OP_JALR: return pc + 4;
      OP_MUL: return prod[XLEN-1:0];
      OP_MULHU: return prod[2*XLEN-1:XLEN];
      OP_DIVU: return (b == '0) ? '1 : a / b;
      OP_REMU: return (b == '0) ? a : a % b;
      OP_DIV: return (b == '0) ? '1 : (ovf ? a : $unsigned(sa / sb));
      OP_REM: return (b == '0) ? a : (ovf ? '0 : $unsigned(sa % sb));
      default: return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Outputs of the previous ALU or branch issue
  task automatic settle_pending();
    if (pend)
    begin
      check("valid", 1, ex_valid_o);
      check("result", pend_r, ex_r_o);
      check("pc", pend_pc, ex_pc_o);
      check("flush", pend_flush, bu_flush_o);
      check("btaken", pend_taken, bu_btaken_o);
      if (pend_br)
      begin
        check("next pc", pend_nxt, bu_nxt_pc_o);
      end
      pend = 1'b0;
    end
  endtask

  // Issues one instruction; ALU and branch issues run back to back
  task automatic run_op(input ex_op_t op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input logic bypa, input logic bypb);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] ea;
    logic [XLEN-1:0] eb;
    logic [XLEN-1:0] target;
    logic            pred;
    logic            taken;
    logic            seen;
    int              lat;
    pc     = $urandom & 32'hffff_fffc;
    imm    = $urandom_range(0, 8190) - 4096;
    imm[0] = 1'b0;
    pred   = 1'($urandom_range(0, 1));
    @(posedge clk_i);
    id_valid_i    <= 1'b1;
    id_op_i       <= op;
    id_pc_i       <= pc;
    id_imm_i      <= imm;
    id_opa_i      <= a;
    id_opb_i      <= b;
    id_bypa_i     <= bypa;
    id_bypb_i     <= bypb;
    id_bp_taken_i <= pred;
    @(negedge clk_i);
    settle_pending();
    ea     = bypa ? last_r : a;
    eb     = bypb ? last_r : b;
    last_r = ref_result(op, ea, eb, pc);
    taken  = ref_taken(op, ea, eb);
    target = (op == OP_JALR) ? ((ea + imm) & 32'hffff_fffe) : pc + imm;
    if (op_unit(op) == UNIT_MULDIV)
    begin
      @(posedge clk_i);
      id_valid_i <= 1'b0;
      seen = 1'b0;
      lat  = 0;
      do
      begin
        @(negedge clk_i);
        lat++;
        seen |= ex_stall_o;
      end
      while (!ex_valid_o);
      checks++;
      if (!seen)
      begin
        errors++;
        $display("Error %s: ex_stall_o never rose before the %s result", test_name, op.name());
      end
      check("latency", 33, lat);
      check("mul/div result", last_r, ex_r_o);
      check("pc", pc, ex_pc_o);
    end
    else
    begin
      pend       = 1'b1;
      pend_br    = (op_unit(op) == UNIT_BRANCH);
      pend_r     = last_r;
      pend_pc    = pc;
      pend_taken = taken;
      pend_flush = pend_br && (taken != pred);
      pend_nxt   = taken ? target : pc + 4;
    end
  endtask

  task automatic drain();
    @(posedge clk_i);
    id_valid_i <= 1'b0;
    @(negedge clk_i);
    settle_pending();
  endtask

  task automatic report_test(input int n);
    $display("Test %s done: %0d issues, %0d errors", test_name, n, errors - base_errors);
    base_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int              k;
    ex_op_t          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            bypa;
    void'($urandom(32'h955d0374));
    rst_ni        = 1'b0;
    id_valid_i    = 1'b0;
    id_op_i       = OP_NOP;
    id_pc_i       = '0;
    id_imm_i      = '0;
    id_opa_i      = '0;
    id_opb_i      = '0;
    id_bypa_i     = 1'b0;
    id_bypb_i     = 1'b0;
    id_bp_taken_i = 1'b0;
    pend          = 1'b0;
    last_r        = '0;
    checks        = 0;
    errors        = 0;
    base_errors   = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "reset";
    @(negedge clk_i);
    check("pc", PC_INIT, ex_pc_o);
    check("valid", 0, ex_valid_o);
    check("stall", 0, ex_stall_o);
    check("flush", 0, bu_flush_o);
    report_test(0);

    test_name = "alu";
    for (k = 0; k < N_ALU; k++)
    begin
      op = ex_op_t'(5'($urandom_range(0, 9)));
      a  = $urandom;
      // Equal operands now and then for the compares
      b  = ($urandom_range(0, 3) == 0) ? a : $urandom;
      run_op(op, a, b, 1'b0, 1'b0);
    end
    drain();
    report_test(N_ALU);

    test_name = "branch";
    for (k = 0; k < N_BRANCH; k++)
    begin
      op = ex_op_t'(5'($urandom_range(10, 17)));
      a  = $urandom;
      b  = ($urandom_range(0, 2) == 0) ? a : $urandom;
      run_op(op, a, b, 1'b0, 1'b0);
    end
    drain();
    report_test(N_BRANCH);

    test_name = "muldiv";
    for (k = 0; k < N_MULDIV; k++)
    begin
      op = ex_op_t'(5'($urandom_range(18, 23)));
      a  = $urandom;
      b  = $urandom;
      if (k % 10 == 0)
      begin
        b = '0;
      end
      else if (k % 10 == 1)
      begin
        op = (k % 20 == 1) ? OP_DIV : OP_REM;
        a  = 32'h8000_0000;
        b  = '1;
      end
      run_op(op, a, b, 1'b0, 1'b0);
    end
    drain();
    report_test(N_MULDIV);

    test_name = "bypass";
    for (k = 0; k < N_BYPASS; k++)
    begin
      op   = ex_op_t'(5'($urandom_range(0, 24)));
      a    = $urandom;
      b    = $urandom;
      bypa = 1'($urandom_range(0, 1));
      // Mul/div followed by a forwarded consumer
      if (k % 8 == 0)
      begin
        op = OP_MUL;
      end
      else if (k % 8 == 1)
      begin
        bypa = 1'b1;
      end
      run_op(op, a, b, bypa, 1'($urandom_range(0, 1)));
    end
    drain();
    report_test(N_BYPASS);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
